/* design/cnn_pkg.sv */
package cnn_pkg;

    // Window geometry
    localparam int NUM_TAPS   = 9;
    localparam int TAP_ADDR_W = 4;

    // Operand widths
    localparam int PIXEL_W  = 16;
    localparam int WEIGHT_W = 16;

    // Nine full-range 16x16 products fit in 36 bits
    localparam int ACC_W    = 36;
    localparam int RESULT_W = 32;

    // Normalization factor is unsigned Q8.8
    localparam int NORM_W    = 16;
    localparam int NORM_FRAC = 8;

    // Average pooling over four results
    localparam int POOL_SIZE  = 4;
    localparam int POOL_SHIFT = 2;       // log2 of POOL_SIZE

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic [TAP_ADDR_W-1:0]      tap_addr_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [RESULT_W-1:0] result_t;
    typedef logic [NORM_W-1:0]          norm_param_t;

endpackage

/* design/tap_buffer.sv */
`timescale 1ns/100ps

// Holds the nine taps of one 3x3 window, shared by pixels and weights
module tap_buffer #(
    parameter type tap_t = cnn_pkg::pixel_t
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               we_i,
    input  cnn_pkg::tap_addr_t addr_i,
    input  tap_t               data_i,
    output tap_t               taps_o [cnn_pkg::NUM_TAPS]
);
    import cnn_pkg::*;

    logic addr_ok;

    // Addresses past the last tap are dropped
    assign addr_ok = (addr_i < NUM_TAPS);

    // All taps are read in parallel by the multiplier array.
    // A write lands on the clock edge, so a start in the same cycle
    // still multiplies the previous value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps_o[i] <= '0;
            end
        end else if (we_i && addr_ok) begin
            taps_o[addr_i] <= data_i;  // One entry per strobe
        end
    end

endmodule

/* design/conv_mac_tree.sv */
`timescale 1ns/100ps

module conv_mac_tree (
    input  logic             clk,
    input  logic             reset,
    input  logic             start_i,
    input  cnn_pkg::pixel_t  pixels_i  [cnn_pkg::NUM_TAPS],
    input  cnn_pkg::weight_t weights_i [cnn_pkg::NUM_TAPS],
    output cnn_pkg::acc_t    sum_o,
    output logic             sum_valid_o
);
    import cnn_pkg::*;

    // Stage one registers
    logic signed [PIXEL_W+WEIGHT_W-1:0] prod_q [NUM_TAPS];
    logic                               prod_valid_q;

    // Adder tree levels, 9 -> 5 -> 3 -> 2 -> 1
    acc_t prod_ext [NUM_TAPS];
    acc_t lvl1     [(NUM_TAPS + 1) / 2];
    acc_t lvl2     [(NUM_TAPS + 3) / 4];
    acc_t lvl3     [(NUM_TAPS + 7) / 8];
    acc_t tree_sum;

    // Stage one, one signed product per tap pair
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_valid_q <= 1'b0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            prod_valid_q <= start_i;
            if (start_i) begin
                for (int i = 0; i < NUM_TAPS; i++) begin
                    prod_q[i] <= pixels_i[i] * weights_i[i];
                end
            end
        end
    end

    // Sign extend the products to the sum width
    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod_ext[i] = prod_q[i];
        end
    end

    // Pairwise reduction, an odd last entry passes to the next level
    always_comb begin
        for (int i = 0; i < $size(lvl1); i++) begin
            if (2 * i + 1 < NUM_TAPS)
                lvl1[i] = prod_ext[2 * i] + prod_ext[2 * i + 1];
            else
                lvl1[i] = prod_ext[2 * i];
        end
        for (int i = 0; i < $size(lvl2); i++) begin
            if (2 * i + 1 < $size(lvl1))
                lvl2[i] = lvl1[2 * i] + lvl1[2 * i + 1];
            else
                lvl2[i] = lvl1[2 * i];
        end
        for (int i = 0; i < $size(lvl3); i++) begin
            if (2 * i + 1 < $size(lvl2))
                lvl3[i] = lvl2[2 * i] + lvl2[2 * i + 1];
            else
                lvl3[i] = lvl2[2 * i];
        end
        tree_sum = lvl3[0] + lvl3[1];   // Final level
    end

    // Stage two, registered sum with its valid bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_o       <= '0;
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= prod_valid_q;
            if (prod_valid_q) begin
                sum_o <= tree_sum;
            end
        end
    end

endmodule

/* design/act_stage.sv */
`timescale 1ns/100ps

module act_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  cnn_pkg::acc_t        sum_i,
    input  logic                 sum_valid_i,
    input  cnn_pkg::norm_param_t norm_param_i,
    input  logic                 norm_en_i,
    input  logic                 relu_en_i,
    output cnn_pkg::result_t     act_o,
    output logic                 act_valid_o
);
    import cnn_pkg::*;

    logic signed [ACC_W+NORM_W:0] scaled;    // Full product, one extra sign bit
    logic signed [ACC_W+NORM_W:0] scaled_sh;
    result_t                      norm_val;
    result_t                      act_next;

    // Q8.8 factor is unsigned, zero extend before the signed multiply
    assign scaled    = sum_i * $signed({1'b0, norm_param_i});
    assign scaled_sh = scaled >>> NORM_FRAC;

    always_comb begin
        if (norm_en_i)
            norm_val = scaled_sh[RESULT_W-1:0];
        else
            norm_val = sum_i[RESULT_W-1:0];  // Plain truncation

        // ReLU clamps on the truncated value
        if (relu_en_i && norm_val[RESULT_W-1])
            act_next = '0;
        else
            act_next = norm_val;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            act_o       <= '0;
            act_valid_o <= 1'b0;
        end else begin
            act_valid_o <= sum_valid_i;
            if (sum_valid_i) begin
                act_o <= act_next;
            end
        end
    end

endmodule

/* design/avg_pool.sv */
`timescale 1ns/100ps

module avg_pool (
    input  logic             clk,
    input  logic             reset,
    input  cnn_pkg::result_t act_i,
    input  logic             act_valid_i,
    input  logic             pool_en_i,
    output cnn_pkg::result_t result_o,
    output logic             result_valid_o
);
    import cnn_pkg::*;

    // Two extra bits hold the sum of four results without overflow
    logic signed [RESULT_W+POOL_SHIFT-1:0] acc_q;
    logic signed [RESULT_W+POOL_SHIFT-1:0] group_sum;
    logic signed [RESULT_W+POOL_SHIFT-1:0] group_avg;
    logic [POOL_SHIFT-1:0]                 count_q;
    logic                                  last_in_group;

    assign group_sum     = acc_q + act_i;
    assign group_avg     = group_sum >>> POOL_SHIFT;    // Floor division
    assign last_in_group = (count_q == POOL_SIZE - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q          <= '0;
            count_q        <= '0;
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else if (!pool_en_i) begin
            // Pass through, group state parked at zero
            acc_q          <= '0;
            count_q        <= '0;
            result_valid_o <= act_valid_i;
            if (act_valid_i) begin
                result_o <= act_i;
            end
        end else begin
            result_valid_o <= act_valid_i && last_in_group;
            if (act_valid_i) begin
                count_q <= count_q + 1'b1;  // Wraps after the fourth input
                if (last_in_group) begin
                    acc_q    <= '0;
                    result_o <= group_avg[RESULT_W-1:0];
                end else begin
                    acc_q <= group_sum;
                end
            end
        end
    end

endmodule

/* design/cnn_conv_top.sv */
`timescale 1ns/100ps

module cnn_conv_top (
    input  logic                 clk,
    input  logic                 reset,
    // Weight tap writes
    input  logic                 weight_we_i,
    input  cnn_pkg::tap_addr_t   weight_addr_i,
    input  cnn_pkg::weight_t     weight_data_i,
    // Pixel tap writes
    input  logic                 pixel_we_i,
    input  cnn_pkg::tap_addr_t   pixel_addr_i,
    input  cnn_pkg::pixel_t      pixel_data_i,
    input  logic                 start_i,
    // Static configuration
    input  cnn_pkg::norm_param_t norm_param_i,
    input  logic                 norm_en_i,
    input  logic                 relu_en_i,
    input  logic                 pool_en_i,
    output cnn_pkg::result_t     result_o,
    output logic                 result_valid_o
);
    import cnn_pkg::*;

    pixel_t  pixel_taps  [NUM_TAPS];
    weight_t weight_taps [NUM_TAPS];
    acc_t    sum;
    logic    sum_valid;
    result_t act;
    logic    act_valid;

    tap_buffer #(
        .tap_t(pixel_t)
    ) pixel_buf (
        .clk    (clk),
        .reset  (reset),
        .we_i   (pixel_we_i),
        .addr_i (pixel_addr_i),
        .data_i (pixel_data_i),
        .taps_o (pixel_taps)
    );

    tap_buffer #(
        .tap_t(weight_t)
    ) weight_buf (
        .clk    (clk),
        .reset  (reset),
        .we_i   (weight_we_i),
        .addr_i (weight_addr_i),
        .data_i (weight_data_i),
        .taps_o (weight_taps)
    );

    // Products one cycle after start, sum one cycle later
    conv_mac_tree u_mac_tree (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start_i),
        .pixels_i    (pixel_taps),
        .weights_i   (weight_taps),
        .sum_o       (sum),
        .sum_valid_o (sum_valid)
    );

    act_stage u_act (
        .clk          (clk),
        .reset        (reset),
        .sum_i        (sum),
        .sum_valid_i  (sum_valid),
        .norm_param_i (norm_param_i),
        .norm_en_i    (norm_en_i),
        .relu_en_i    (relu_en_i),
        .act_o        (act),
        .act_valid_o  (act_valid)
    );

    avg_pool u_pool (
        .clk            (clk),
        .reset          (reset),
        .act_i          (act),
        .act_valid_i    (act_valid),
        .pool_en_i      (pool_en_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

endmodule

/* bench/cnn_conv_chk.sv */
`timescale 1ns/100ps

module cnn_conv_chk (
    input logic             clk,
    input logic             reset,
    input logic             start_i,
    input logic             pool_en_i,
    input logic             relu_en_i,
    input cnn_pkg::result_t result_i,
    input logic             result_valid_i
);
    int failed_assertions = 0;

    // Output stays quiet during reset
    assert property (@(posedge clk) reset |-> !result_valid_i)
        else begin
            failed_assertions++;
            $error("result_valid_o high during reset");
        end

    // Fixed four cycle latency in pass-through mode
    assert property (@(posedge clk) disable iff (reset)
        (start_i && !pool_en_i) |-> ##4 result_valid_i)
        else begin
            failed_assertions++;
            $error("no result 4 cycles after start_i");
        end

    // Rectified results are never negative
    assert property (@(posedge clk) disable iff (reset)
        (relu_en_i && result_valid_i) |-> !result_i[cnn_pkg::RESULT_W-1])
        else begin
            failed_assertions++;
            $error("negative result_o with relu_en_i high");
        end

endmodule

bind cnn_conv_top cnn_conv_chk u_chk (
    .clk(clk), .reset(reset), .start_i(start_i), .pool_en_i(pool_en_i),
    .relu_en_i(relu_en_i), .result_i(result_o), .result_valid_i(result_valid_o)
);

/* bench/cnn_conv_tb.sv */
`timescale 1ns/100ps

module cnn_conv_tb;
    import cnn_pkg::*;

    // Cycle budget of each test sizes the watchdog
    localparam int TEST_CYCLES     = 60 + 140 + 60 + 200 + 160;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 2 + 200;
    localparam int DRAIN_LIMIT     = 20;
    localparam int QUIET_CYCLES    = 6;

    logic        clk;
    logic        reset;
    logic        weight_we_i;
    tap_addr_t   weight_addr_i;
    weight_t     weight_data_i;
    logic        pixel_we_i;
    tap_addr_t   pixel_addr_i;
    pixel_t      pixel_data_i;
    logic        start_i;
    norm_param_t norm_param_i;
    logic        norm_en_i;
    logic        relu_en_i;
    logic        pool_en_i;
    result_t     result_o;
    logic        result_valid_o;

    pixel_t  pix_sh [NUM_TAPS];    // Shadow copy of the window
    weight_t wgt_sh [NUM_TAPS];
    result_t exp_q  [$];
    result_t mon_expected;
    longint  pool_sum;
    int      pool_cnt;
    int      result_count;
    int      mismatches;
    int      other_errors;

    cnn_conv_top uut (.*);

    always #2 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Dot product with optional Q8.8 scaling and ReLU on the low 32 bits
    function automatic result_t model_result(input logic use_norm, input logic use_relu,
                                             input norm_param_t norm);
        longint  dot;
        longint  scaled;
        result_t r;
        dot = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            dot += longint'(pix_sh[i]) * longint'(wgt_sh[i]);
        end
        if (use_norm) begin
            scaled = (dot * longint'(norm)) >>> NORM_FRAC;
            r = scaled[RESULT_W-1:0];
        end else begin
            r = dot[RESULT_W-1:0];
        end
        if (use_relu && r < 0)
            r = 0;
        return r;
    endfunction

    task automatic write_pair(input int addr, input pixel_t p, input weight_t w);
        pixel_we_i    = 1'b1;
        pixel_addr_i  = addr;
        pixel_data_i  = p;
        weight_we_i   = 1'b1;
        weight_addr_i = addr;
        weight_data_i = w;
        next_cycle();
        pixel_we_i  = 1'b0;
        weight_we_i = 1'b0;
        if (addr < NUM_TAPS) begin
            pix_sh[addr] = p;
            wgt_sh[addr] = w;
        end
    endtask

    // Mode 0 gives full-range taps, mode 1 a positive sum and mode 2 a negative sum
    task automatic load_window(input int mode);
        pixel_t  p;
        weight_t w;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (mode == 0) begin
                p = $urandom;
                w = $urandom;
            end else begin
                p = $urandom_range(4095, 1);
                w = $urandom_range(4095, 1);
                if (mode == 2)
                    w = -w;
            end
            write_pair(i, p, w);
        end
    endtask

    // Queue what the window gives at this start
    task automatic push_expected();
        result_t r;
        longint  avg;
        r = model_result(norm_en_i, relu_en_i, norm_param_i);
        if (!pool_en_i) begin
            exp_q.push_back(r);
        end else begin
            pool_sum += r;  // Groups of four when pooling
            pool_cnt++;
            if (pool_cnt == POOL_SIZE) begin
                avg = pool_sum >>> POOL_SHIFT;
                exp_q.push_back(avg[RESULT_W-1:0]);
                pool_sum = 0;
                pool_cnt = 0;
            end
        end
    endtask

    task automatic pulse_start();
        push_expected();
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("error at %0t: %0d expected results never came out", $time, exp_q.size());
            exp_q.delete();
        end
        repeat (QUIET_CYCLES) next_cycle();
    endtask

    task automatic set_config(input logic ne, input logic re, input logic pe,
                              input norm_param_t np);
        norm_en_i    = ne;
        relu_en_i    = re;
        pool_en_i    = pe;
        norm_param_i = np;
        pool_sum     = 0;
        pool_cnt     = 0;
        next_cycle();
    endtask

    task automatic reset_and_single_tap();
        int latency;
        set_config(0, 0, 0, '0);
        pulse_start();  // Empty buffers give zero
        wait_drain();
        for (int i = 0; i < NUM_TAPS; i++) begin
            write_pair(i, $urandom, (i == 4) ? 1 : 0);
        end
        pulse_start();
        latency = 1;
        while (!result_valid_o && latency < DRAIN_LIMIT) begin
            next_cycle();
            latency++;
        end
        if (latency != 4) begin
            mismatches++;
            $display("mismatch at %0t: result_valid_o latency got %0d expected 4", $time,
                     latency);
        end
        if (result_o !== result_t'(pix_sh[4])) begin
            mismatches++;
            $display("mismatch at %0t: result_o got %0d expected %0d", $time, result_o,
                     result_t'(pix_sh[4]));
        end
        wait_drain();
    endtask

    task automatic random_windows();
        set_config(0, 0, 0, '0);
        repeat (5) begin
            load_window(0);
            pulse_start();
            wait_drain();
        end
        for (int a = NUM_TAPS; a < 16; a++) begin
            write_pair(a, $urandom, $urandom);  // Out of range so the window stays unchanged
        end
        pulse_start();
        wait_drain();
    endtask

    task automatic back_to_back_starts();
        set_config(0, 0, 0, '0);
        load_window(0);
        for (int i = 0; i < 4; i++) begin
            push_expected();                 // Sees the window before this write
            start_i      = 1'b1;
            pixel_we_i   = 1'b1;
            pixel_addr_i = i;
            pixel_data_i = $urandom;
            next_cycle();
            pix_sh[i] = pixel_data_i;
        end
        pixel_we_i = 1'b0;
        pulse_start();
        wait_drain();
    endtask

    task automatic norm_and_relu();
        repeat (2) begin
            set_config(1, 0, 0, $urandom);
            repeat (2) begin
                load_window(0);
                pulse_start();
                wait_drain();
            end
        end
        set_config(0, 1, 0, '0);
        for (int m = 0; m < 4; m++) begin
            load_window((m % 2) + 1);
            pulse_start();
            wait_drain();
        end
        set_config(1, 1, 0, $urandom);
        load_window(0);
        pulse_start();
        wait_drain();
    endtask

    task automatic pooling_groups();
        int count_before;
        set_config(0, 0, 1, '0);
        count_before = result_count;
        repeat (2 * POOL_SIZE) begin
            load_window(0);
            pulse_start();
            repeat (QUIET_CYCLES) next_cycle();  // Room for a stray early result to show
        end
        wait_drain();
        if (result_count - count_before != 2) begin
            other_errors++;
            $display("error at %0t: pooling gave %0d results instead of 2", $time,
                     result_count - count_before);
        end
        set_config(0, 0, 0, '0);
    endtask

    always @(negedge clk) begin
        if (!reset && result_valid_o) begin
            result_count++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("error at %0t: result_valid_o pulsed with no result due", $time);
            end else begin
                mon_expected = exp_q.pop_front();
                if (result_o !== mon_expected) begin
                    mismatches++;
                    $display("mismatch at %0t: result_o got %0d expected %0d", $time,
                             result_o, mon_expected);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error at %0t: watchdog expired, the run did not complete", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h363932d7));
        clk           = 1'b0;
        reset         = 1'b1;
        weight_we_i   = 1'b0;
        weight_addr_i = '0;
        weight_data_i = '0;
        pixel_we_i    = 1'b0;
        pixel_addr_i  = '0;
        pixel_data_i  = '0;
        start_i       = 1'b0;
        norm_param_i  = '0;
        norm_en_i     = 1'b0;
        relu_en_i     = 1'b0;
        pool_en_i     = 1'b0;
        pool_sum      = 0;
        pool_cnt      = 0;
        result_count  = 0;
        mismatches    = 0;
        other_errors  = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            pix_sh[i] = '0;
            wgt_sh[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        next_cycle();
        reset_and_single_tap();
        random_windows();
        back_to_back_starts();
        norm_and_relu();
        pooling_groups();
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, uut.u_chk.failed_assertions);
        if (mismatches == 0 && other_errors == 0 && uut.u_chk.failed_assertions == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
design/cnn_pkg.sv
design/tap_buffer.sv
design/conv_mac_tree.sv
design/act_stage.sv
design/avg_pool.sv
design/cnn_conv_top.sv
bench/cnn_conv_chk.sv
bench/cnn_conv_tb.sv
